//--- verilog/loader_pkg.sv
package loader_pkg;

    // bus and character widths.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  trans_t;
    typedef logic [2:0]  size_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TYPE,
        ST_COUNT,
        ST_ADDR,
        ST_DATA,
        ST_CSUM,
        ST_EOL,
        ST_ERROR
    } parser_state_t;

    // ahb-lite transfer codes.
    localparam trans_t HTRANS_IDLE   = 2'b00;
    localparam trans_t HTRANS_NONSEQ = 2'b10;

    localparam size_t HSIZE_BYTE = 3'b000;
    localparam size_t HSIZE_HALF = 3'b001;
    localparam size_t HSIZE_WORD = 3'b010;

    // uart oversampling.
    localparam int CLOCKS_PER_BIT = 16;
    localparam int BIT_CNT_BITS   = $clog2(CLOCKS_PER_BIT);

    // 1 KiB ram organised as words.
    localparam int RAM_ADDR_BITS = 10;
    localparam int RAM_WORD_BITS = RAM_ADDR_BITS - 2;

    // s-record characters and checksum target.
    localparam byte_t CHAR_S    = 8'h53;
    localparam byte_t CHAR_CR   = 8'h0D;
    localparam byte_t CHAR_LF   = 8'h0A;
    localparam byte_t CSUM_GOOD = 8'hFF;

endpackage

//--- verilog/uart_receiver.sv
`timescale 1ns/10ps

module uart_receiver (
    input  logic              clock,
    input  logic              rst,
    input  logic              rx,
    output loader_pkg::byte_t rx_byte,
    output logic              rx_valid
);
    import loader_pkg::*;

    logic                    rx_meta;
    logic                    rx_sync;
    logic                    rx_prev;
    logic                    busy;
    logic [BIT_CNT_BITS-1:0] tick_cnt;
    logic [3:0]              bit_idx;
    byte_t                   shift_reg;

    // line idles high.
    always_ff @(posedge clock) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clock) begin
        rx_valid <= 1'b0;
        if (rst) begin
            busy     <= 1'b0;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else if (!busy) begin
            if (rx_prev && !rx_sync) begin  // start edge.
                busy     <= 1'b1;
                tick_cnt <= BIT_CNT_BITS'(CLOCKS_PER_BIT / 2 - 1);
                bit_idx  <= '0;
            end
        end else if (tick_cnt != '0) begin
            tick_cnt <= tick_cnt - 1'b1;
        end else begin
            // mid-bit sample point.
            tick_cnt <= BIT_CNT_BITS'(CLOCKS_PER_BIT - 1);
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 4'd0) begin
                if (rx_sync)
                    busy <= 1'b0;  // glitch rather than a start bit.
            end else if (bit_idx == 4'd9) begin
                busy     <= 1'b0;
                rx_valid <= rx_sync;  // low stop bit drops the frame.
            end
        end
    end

    // lsb first.
    always_ff @(posedge clock) begin
        if (busy && tick_cnt == '0 && bit_idx != 4'd0 && bit_idx != 4'd9)
            shift_reg <= {rx_sync, shift_reg[7:1]};
    end

    assign rx_byte = shift_reg;

    a_single_strobe: assert property (
        @(posedge clock) disable iff (rst) rx_valid |=> !rx_valid
    );

endmodule

//--- verilog/srec_parser.sv
`timescale 1ns/10ps

module srec_parser (
    input  logic              clock,
    input  logic              rst,
    input  loader_pkg::byte_t rx_byte,
    input  logic              rx_valid,
    output logic              in_progress,
    output logic              format_error,
    output logic              checksum_error,
    output loader_pkg::byte_t error_location,
    output loader_pkg::addr_t wr_addr,
    output loader_pkg::byte_t wr_byte,
    output logic              wr_valid
);
    import loader_pkg::*;

    parser_state_t state;
    byte_t         record_index;
    logic          have_hi;
    logic [3:0]    hi_nibble;
    logic [2:0]    addr_left;
    byte_t         remaining;
    byte_t         sum;
    addr_t         addr;
    logic          store;
    logic          terminate;

    logic          hex_ok;
    logic [3:0]    nibble;
    logic          type_ok;
    logic [2:0]    type_len;
    logic          hex_state;
    logic          eol_char;
    logic          byte_done;
    byte_t         full_byte;
    byte_t         sum_next;
    logic          fmt_err;
    logic          csum_err;

    always_comb begin
        hex_ok = 1'b1;
        nibble = 4'h0;
        if (rx_byte >= "0" && rx_byte <= "9")
            nibble = rx_byte[3:0];
        else if ((rx_byte >= "A" && rx_byte <= "F") || (rx_byte >= "a" && rx_byte <= "f"))
            nibble = rx_byte[3:0] + 4'd9;
        else
            hex_ok = 1'b0;
    end

    // address bytes per record type.
    always_comb begin
        type_ok = 1'b1;
        case (rx_byte)
            "0", "1", "5", "9": type_len = 3'd2;
            "2", "8":           type_len = 3'd3;
            "3", "7":           type_len = 3'd4;
            default: begin
                type_ok  = 1'b0;
                type_len = 3'd2;
            end
        endcase
    end

    assign hex_state = state inside {ST_COUNT, ST_ADDR, ST_DATA, ST_CSUM};
    assign eol_char  = (rx_byte == CHAR_CR) || (rx_byte == CHAR_LF);
    assign byte_done = rx_valid && hex_state && hex_ok && have_hi;
    assign full_byte = {hi_nibble, nibble};
    assign sum_next  = sum + full_byte;

    always_comb begin
        fmt_err = 1'b0;
        if (rx_valid) begin
            case (state)
                ST_IDLE:  fmt_err = in_progress && rx_byte != CHAR_S && !eol_char;
                ST_TYPE:  fmt_err = !type_ok;
                ST_EOL:   fmt_err = !eol_char;
                ST_ERROR: fmt_err = 1'b0;
                default:  fmt_err = !hex_ok ||
                                    (byte_done && state == ST_COUNT &&
                                     full_byte <= {5'd0, addr_left});
            endcase
        end
    end

    assign csum_err = byte_done && state == ST_CSUM && sum_next != CSUM_GOOD;

    always_ff @(posedge clock) begin
        wr_valid <= 1'b0;
        if (rst) begin
            state          <= ST_IDLE;
            in_progress    <= 1'b0;
            format_error   <= 1'b0;
            checksum_error <= 1'b0;
            error_location <= '0;
            record_index   <= '0;
            have_hi        <= 1'b0;
        end else if (fmt_err || csum_err) begin
            state          <= ST_ERROR;
            in_progress    <= 1'b0;
            format_error   <= fmt_err;
            checksum_error <= csum_err;
            error_location <= record_index;
        end else if (rx_valid) begin
            if (hex_state)
                have_hi <= !have_hi;
            case (state)
                ST_IDLE, ST_ERROR: begin
                    if (rx_byte == CHAR_S) begin
                        state <= ST_TYPE;
                        if (!in_progress) begin  // first record of a load.
                            in_progress    <= 1'b1;
                            format_error   <= 1'b0;
                            checksum_error <= 1'b0;
                            record_index   <= '0;
                        end
                    end
                end
                ST_TYPE: begin
                    state   <= ST_COUNT;
                    have_hi <= 1'b0;
                end
                ST_COUNT: if (byte_done) state <= ST_ADDR;
                ST_ADDR: begin
                    if (byte_done && addr_left == 3'd1)
                        state <= (remaining == 8'd2) ? ST_CSUM : ST_DATA;
                end
                ST_DATA: begin
                    if (byte_done) begin
                        wr_valid <= store;
                        if (remaining == 8'd2)
                            state <= ST_CSUM;
                    end
                end
                ST_CSUM: if (byte_done) state <= ST_EOL;
                ST_EOL: begin
                    state        <= ST_IDLE;
                    record_index <= record_index + 1'b1;
                    if (terminate)
                        in_progress <= 1'b0;  // s7/s8/s9 ends the load.
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rx_valid)
            hi_nibble <= nibble;
        if (rx_valid && state == ST_TYPE) begin
            addr_left <= type_len;
            store     <= rx_byte inside {"1", "2", "3"};
            terminate <= rx_byte inside {"7", "8", "9"};
        end
        if (byte_done) begin
            case (state)
                ST_COUNT: begin
                    remaining <= full_byte;
                    sum       <= full_byte;
                    addr      <= '0;
                end
                ST_ADDR: begin
                    remaining <= remaining - 1'b1;
                    addr_left <= addr_left - 1'b1;
                    sum       <= sum_next;
                    addr      <= {addr[23:0], full_byte};
                end
                ST_DATA: begin
                    remaining <= remaining - 1'b1;
                    sum       <= sum_next;
                    addr      <= addr + 1'b1;
                    wr_addr   <= addr;
                    wr_byte   <= full_byte;
                end
                default: ;
            endcase
        end
    end

    a_no_write_on_error: assert property (
        @(posedge clock) disable iff (rst) wr_valid |-> !(format_error || checksum_error)
    );

endmodule

//--- verilog/srec_ahb_bridge.sv
`timescale 1ns/10ps

module srec_ahb_bridge (
    input  logic               clock,
    input  logic               rst,
    input  logic               big_endian,
    input  loader_pkg::addr_t  wr_addr,
    input  loader_pkg::byte_t  wr_byte,
    input  logic               wr_valid,
    input  logic               hready,
    output loader_pkg::addr_t  haddr,
    output loader_pkg::trans_t htrans,
    output loader_pkg::size_t  hsize,
    output logic               hwrite,
    output loader_pkg::data_t  hwdata
);
    import loader_pkg::*;

    logic  addr_phase;
    logic  data_phase;
    byte_t byte_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            addr_phase <= 1'b0;
            data_phase <= 1'b0;
        end else begin
            if (wr_valid)
                addr_phase <= 1'b1;
            else if (hready)
                addr_phase <= 1'b0;  // address accepted.
            if (hready)
                data_phase <= addr_phase;
        end
    end

    // big endian flips the lane within the word.
    always_ff @(posedge clock) begin
        if (wr_valid) begin
            haddr  <= big_endian ? {wr_addr[31:2], ~wr_addr[1:0]} : wr_addr;
            byte_q <= wr_byte;
        end
    end

    assign htrans = addr_phase ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign hwrite = addr_phase;
    assign hsize  = HSIZE_BYTE;
    assign hwdata = {4{byte_q}};  // slave picks the lane.

    // parser spacing leaves no room for a second write in flight.
    a_no_overlap: assert property (
        @(posedge clock) disable iff (rst) wr_valid |-> !(addr_phase || data_phase)
    );

endmodule

//--- verilog/ahb_ram_slave.sv
`timescale 1ns/10ps

module ahb_ram_slave (
    input  logic               clock,
    input  logic               rst,
    input  loader_pkg::addr_t  haddr,
    input  loader_pkg::trans_t htrans,
    input  loader_pkg::size_t  hsize,
    input  logic               hwrite,
    input  loader_pkg::data_t  hwdata,
    output loader_pkg::data_t  hrdata,
    output logic               hready,
    output logic               hresp
);
    import loader_pkg::*;

    data_t                    mem [2**RAM_WORD_BITS];
    logic                     nonseq;
    logic [3:0]               be;
    logic                     wr_pending;
    logic [3:0]               wr_be;
    logic [RAM_WORD_BITS-1:0] wr_word;
    logic [RAM_WORD_BITS-1:0] rd_word;

    assign nonseq = htrans == HTRANS_NONSEQ;

    always_comb begin
        case (hsize)
            HSIZE_BYTE: be = 4'b0001 << haddr[1:0];
            HSIZE_HALF: be = haddr[1] ? 4'b1100 : 4'b0011;
            default:    be = 4'b1111;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst)
            wr_pending <= 1'b0;
        else
            wr_pending <= nonseq && hwrite;
    end

    // upper address bits wrap.
    always_ff @(posedge clock) begin
        if (nonseq) begin
            wr_word <= haddr[RAM_ADDR_BITS-1:2];
            wr_be   <= be;
            rd_word <= haddr[RAM_ADDR_BITS-1:2];
        end
    end

    always_ff @(posedge clock) begin
        if (wr_pending) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i])
                    mem[wr_word][8*i +: 8] <= hwdata[8*i +: 8];
            end
        end
    end

    assign hrdata = mem[rd_word];  // data phase.
    assign hready = 1'b1;
    assign hresp  = 1'b0;

    a_size_legal: assert property (
        @(posedge clock) disable iff (rst) nonseq |-> hsize <= HSIZE_WORD
    );

endmodule

//--- verilog/ahb_loader_top.sv
`timescale 1ns/10ps

module ahb_loader_top (
    input  logic               clock,
    input  logic               rst,
    input  logic               big_endian,
    input  logic               uart_rx,
    input  loader_pkg::addr_t  haddr,
    input  loader_pkg::trans_t htrans,
    input  loader_pkg::size_t  hsize,
    input  logic               hwrite,
    input  loader_pkg::data_t  hwdata,
    output loader_pkg::data_t  hrdata,
    output logic               hready,
    output logic               hresp,
    output logic               in_progress,
    output logic               format_error,
    output logic               checksum_error,
    output loader_pkg::byte_t  error_location
);
    import loader_pkg::*;

    byte_t  rx_byte;
    logic   rx_valid;
    addr_t  wr_addr;
    byte_t  wr_byte;
    logic   wr_valid;

    addr_t  loader_haddr;
    trans_t loader_htrans;
    size_t  loader_hsize;
    logic   loader_hwrite;
    data_t  loader_hwdata;

    uart_receiver i_uart_receiver (
        .clock    ( clock    ),
        .rst      ( rst      ),
        .rx       ( uart_rx  ),
        .rx_byte  ( rx_byte  ),
        .rx_valid ( rx_valid )
    );

    srec_parser i_srec_parser (
        .clock          ( clock          ),
        .rst            ( rst            ),
        .rx_byte        ( rx_byte        ),
        .rx_valid       ( rx_valid       ),
        .in_progress    ( in_progress    ),
        .format_error   ( format_error   ),
        .checksum_error ( checksum_error ),
        .error_location ( error_location ),
        .wr_addr        ( wr_addr        ),
        .wr_byte        ( wr_byte        ),
        .wr_valid       ( wr_valid       )
    );

    srec_ahb_bridge i_srec_ahb_bridge (
        .clock      ( clock         ),
        .rst        ( rst           ),
        .big_endian ( big_endian    ),
        .wr_addr    ( wr_addr       ),
        .wr_byte    ( wr_byte       ),
        .wr_valid   ( wr_valid      ),
        .hready     ( hready        ),
        .haddr      ( loader_haddr  ),
        .htrans     ( loader_htrans ),
        .hsize      ( loader_hsize  ),
        .hwrite     ( loader_hwrite ),
        .hwdata     ( loader_hwdata )
    );

    // loader owns the ram while a load runs.
    ahb_ram_slave i_ahb_ram_slave (
        .clock  ( clock                                  ),
        .rst    ( rst                                    ),
        .haddr  ( in_progress ? loader_haddr  : haddr    ),
        .htrans ( in_progress ? loader_htrans : htrans   ),
        .hsize  ( in_progress ? loader_hsize  : hsize    ),
        .hwrite ( in_progress ? loader_hwrite : hwrite   ),
        .hwdata ( in_progress ? loader_hwdata : hwdata   ),
        .hrdata ( hrdata                                 ),
        .hready ( hready                                 ),
        .hresp  ( hresp                                  )
    );

endmodule

//--- dv/tb_loader.sv
`timescale 1ns/10ps

module tb_loader;
    import loader_pkg::*;

    localparam int PHASE_TIMEOUT = 16;
    localparam int LOAD_TIMEOUT  = 4000;

    logic   clock;
    logic   rst;
    logic   big_endian;
    logic   uart_rx;
    addr_t  haddr;
    trans_t htrans;
    size_t  hsize;
    logic   hwrite;
    data_t  hwdata;
    data_t  hrdata;
    logic   hready;
    logic   hresp;
    logic   in_progress;
    logic   format_error;
    logic   checksum_error;
    byte_t  error_location;

    data_t  ref_words [256];  // expected ram contents.
    byte_t  payload [64];
    int     error_count;
    int     timeout_count;
    integer seed;

    ahb_loader_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic byte_t hex_char(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + {4'd0, n} : 8'h37 + {4'd0, n};
    endfunction

    function automatic int addr_bytes(input byte_t rec_type);
        case (rec_type)
            "2", "8": return 3;
            "3", "7": return 4;
            default:  return 2;
        endcase
    endfunction

    function automatic data_t fill_value(input addr_t a);
        return {6'h2b, a[9:0], 6'h15, ~a[9:0]};
    endfunction

    // lane 3 - a[1:0] when big endian.
    function automatic void ref_store(input addr_t a, input byte_t b);
        logic [1:0] lane;
        lane = big_endian ? 2'd3 - a[1:0] : a[1:0];
        ref_words[a[9:2]][8*lane +: 8] = b;
    endfunction

    // 8N1 frame sent lsb first.
    task automatic send_char(input byte_t c);
        logic [9:0] frame;
        frame = {1'b1, c, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (CLOCKS_PER_BIT) @(posedge clock);
            #1;
        end
    endtask

    task automatic send_hex(input byte_t b);
        send_char(hex_char(b[7:4]));
        send_char(hex_char(b[3:0]));
    endtask

    // corrupt 1 breaks the checksum and 2 puts a non-hex digit in the first data byte.
    task automatic send_record(input byte_t rec_type, input addr_t a, input int n,
                               input int corrupt);
        int    na;
        byte_t count;
        byte_t sum;
        byte_t b;
        na    = addr_bytes(rec_type);
        count = byte_t'(na + n + 1);
        sum   = count;
        send_char("S");
        send_char(rec_type);
        send_hex(count);
        for (int i = na - 1; i >= 0; i--) begin
            b = a[8*i +: 8];
            sum += b;
            send_hex(b);
        end
        for (int i = 0; i < n; i++) begin
            sum += payload[i];
            if (corrupt == 2 && i == 0) begin
                send_char("G");
                send_char(hex_char(payload[i][3:0]));
            end else begin
                send_hex(payload[i]);
                if (corrupt != 2 && rec_type inside {"1", "2", "3"})
                    ref_store(a + i, payload[i]);  // written before the sum is known.
            end
        end
        send_hex(corrupt == 1 ? ~sum ^ 8'h5a : ~sum);
        send_char(8'h0D);
        send_char(8'h0A);
    endtask

    task automatic wait_load_end();
        int n;
        n = 0;
        while (in_progress && n < LOAD_TIMEOUT) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (in_progress) begin
            $display("Timeout: in_progress did not fall at the end of the load");
            timeout_count++;
        end
    endtask

    // one ahb phase held until hready.
    task automatic complete_phase();
        logic done;
        int   n;
        done = 1'b0;
        n    = 0;
        while (!done && n < PHASE_TIMEOUT) begin
            done = hready;
            @(posedge clock);
            #1;
            n++;
        end
        if (!done) begin
            $display("Timeout: hready stayed low on the external port");
            timeout_count++;
        end
    endtask

    task automatic ahb_write(input addr_t a, input data_t d);
        haddr  = a;
        htrans = HTRANS_NONSEQ;
        hsize  = HSIZE_WORD;
        hwrite = 1'b1;
        complete_phase();
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hwdata = d;
        complete_phase();
    endtask

    task automatic ahb_read(input addr_t a, output data_t d);
        haddr  = a;
        htrans = HTRANS_NONSEQ;
        hsize  = HSIZE_WORD;
        hwrite = 1'b0;
        complete_phase();
        htrans = HTRANS_IDLE;
        complete_phase();
        d = hrdata;
    endtask

    task automatic check_status(input logic exp_prog, input logic exp_fmt,
                                input logic exp_csum);
        if (in_progress !== exp_prog) begin
            $display("Error: in_progress = %h, expected %h", in_progress, exp_prog);
            error_count++;
        end
        if (format_error !== exp_fmt) begin
            $display("Error: format_error = %h, expected %h", format_error, exp_fmt);
            error_count++;
        end
        if (checksum_error !== exp_csum) begin
            $display("Error: checksum_error = %h, expected %h", checksum_error, exp_csum);
            error_count++;
        end
    endtask

    task automatic check_memory();
        data_t got;
        for (int i = 0; i < 256; i++) begin
            ahb_read(addr_t'(i * 4), got);
            if (got !== ref_words[i]) begin
                $display("Error: hrdata at %h = %h, expected %h", i * 4, got, ref_words[i]);
                error_count++;
            end
        end
    endtask

    task automatic reset_check();
        data_t got;
        check_status(1'b0, 1'b0, 1'b0);
        if (hready !== 1'b1 || hresp !== 1'b0) begin
            $display("Error: hready = %h, hresp = %h, expected 1 and 0", hready, hresp);
            error_count++;
        end
        for (int i = 0; i < 256; i++) begin
            ref_words[i] = fill_value(addr_t'(i * 4));
            ahb_write(addr_t'(i * 4), ref_words[i]);
        end
        ahb_read(32'h0, got);
        if (got !== fill_value(32'h0)) begin
            $display("Error: hrdata = %h, expected %h", got, fill_value(32'h0));
            error_count++;
        end
    endtask

    task automatic little_endian_load();
        big_endian = 1'b0;
        for (int i = 0; i < 8; i++)
            payload[i] = byte_t'(8'h10 + i);
        send_record("1", 32'h0100, 8, 0);
        check_status(1'b1, 1'b0, 1'b0);  // load still open.
        for (int i = 0; i < 5; i++)
            payload[i] = byte_t'(8'ha0 + 3 * i);
        send_record("1", 32'h0123, 5, 0);
        for (int i = 0; i < 4; i++)
            payload[i] = byte_t'(8'he0 + i);
        send_record("1", 32'h03fe, 4, 0);  // runs past the top and wraps to 0.
        send_record("9", 32'h0100, 0, 0);
        wait_load_end();
        check_status(1'b0, 1'b0, 1'b0);
        check_memory();
    endtask

    task automatic big_endian_load();
        big_endian = 1'b1;
        payload[0] = "H";
        payload[1] = "D";
        payload[2] = "R";
        send_record("0", 32'h0, 3, 0);
        for (int i = 0; i < 6; i++)
            payload[i] = byte_t'(8'h31 + 7 * i);
        send_record("3", 32'h0000_0200, 6, 0);
        send_record("5", 32'h0001, 2, 0);  // carries data that must be ignored.
        for (int i = 0; i < 3; i++)
            payload[i] = byte_t'(8'hc5 - i);
        send_record("3", 32'h1000_0211, 3, 0);
        send_record("7", 32'h0000_0200, 0, 0);
        wait_load_end();
        check_status(1'b0, 1'b0, 1'b0);
        check_memory();
        big_endian = 1'b0;
    endtask

    task automatic checksum_error_load();
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < 4; i++)
                payload[i] = byte_t'(8'h70 + 4 * r + i);
            send_record("1", addr_t'(32'h0040 + 4 * r), 4, (r == 2) ? 1 : 0);
        end
        wait_load_end();
        check_status(1'b0, 1'b0, 1'b1);
        if (error_location !== 8'd2) begin
            $display("Error: error_location = %h, expected %h", error_location, 8'd2);
            error_count++;
        end
        payload[0] = 8'h99;
        payload[1] = 8'h66;
        send_record("1", 32'h0050, 2, 0);
        check_status(1'b1, 1'b0, 1'b0);  // new load clears the flag.
        send_record("9", 32'h0, 0, 0);
        wait_load_end();
        check_status(1'b0, 1'b0, 1'b0);
        check_memory();
    endtask

    task automatic format_error_load();
        for (int i = 0; i < 3; i++)
            payload[i] = byte_t'(8'h5c + i);
        send_record("1", 32'h0060, 3, 0);
        for (int i = 0; i < 4; i++)
            payload[i] = byte_t'(8'h3a + i);
        send_record("1", 32'h0064, 4, 2);
        wait_load_end();
        check_status(1'b0, 1'b1, 1'b0);
        if (error_location !== 8'd1) begin
            $display("Error: error_location = %h, expected %h", error_location, 8'd1);
            error_count++;
        end
        check_memory();
    endtask

    task automatic random_s2_load();
        addr_t a;
        seed = 32'hcd95_1017;
        a    = addr_t'($random(seed)) & 32'h00ff_fffc;
        for (int i = 0; i < 16; i++)
            payload[i] = byte_t'($random(seed));
        send_record("2", a, 16, 0);
        send_record("8", a, 0, 0);
        wait_load_end();
        check_status(1'b0, 1'b0, 1'b0);
        check_memory();
    endtask

    initial begin
        error_count   = 0;
        timeout_count = 0;
        rst           = 1'b1;
        big_endian    = 1'b0;
        uart_rx       = 1'b1;
        haddr         = '0;
        htrans        = HTRANS_IDLE;
        hsize         = HSIZE_WORD;
        hwrite        = 1'b0;
        hwdata        = '0;
        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;
        reset_check();
        little_endian_load();
        big_endian_load();
        checksum_error_load();
        format_error_load();
        random_s2_load();
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- tb.f
verilog/loader_pkg.sv
verilog/uart_receiver.sv
verilog/srec_parser.sv
verilog/srec_ahb_bridge.sv
verilog/ahb_ram_slave.sv
verilog/ahb_loader_top.sv
dv/tb_loader.sv

//--- run.sh
#!/bin/sh
# build and run the loader testbench with verilator.
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_loader -f tb.f -o tb_loader \
    > build.log 2>&1 &&
./obj_dir/tb_loader > sim.log 2>&1 || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "Simulation FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "PASS"
